// File: src.f
verilog/sprite_pkg.sv
verilog/sprite_shifter.sv
verilog/sprite_pixel_pipe.sv
verilog/sprite_collision.sv
verilog/sprite_top.sv
verif/sprite_tb.sv

// File: Makefile
# Verilator build and run of the sprite pixel path testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= sprite_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

FILELIST := src.f
SRCS     := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := ** PASS **

.PHONY: all build run clean

all: run

build: $(BIN)

# the binary is rebuilt only when the file list or one of its sources changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the output is shown and then searched for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: verif/sprite_tb.sv
module sprite_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import sprite_pkg::*;

    localparam int NUM_ROWS = 5;
    // long enough for an expanded multicolour sprite at the largest x to drain
    localparam int SWEEP_LEN = 200;
    localparam int CLK_PER_TICK = 4;
    // collisions judge the bundle one tick after it leaves the pipe
    localparam int FG_LAT = DELAY_PIXELS + 1;
    // flag clears land inside the overlap of row 2, so a re-raise would show
    localparam int FLAG_CLR_X = 66;
    // a beam position that no sprite in the table ever uses
    localparam int IDLE_X = 511;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (SWEEP_LEN + DELAY_PIXELS) * CLK_PER_TICK + 600;

    // one test case holds three data bytes per sprite and an fg range in pixel positions
    typedef struct packed {
        logic [NUM_SPRITES-1:0][23:0]  data;
        sprite_cfg_t [NUM_SPRITES-1:0] cfg;
        logic                          rnd;
        logic [XPOS_W-1:0]             fg_lo;
        logic [XPOS_W-1:0]             fg_hi;
        logic [NUM_SPRITES-1:0]        m2m;
        logic [NUM_SPRITES-1:0]        m2d;
    } row_t;

    logic                          clk_dot4x;
    logic                          rst;
    logic                          dot_tick;
    logic [XPOS_W-1:0]             xpos;
    sprite_cfg_t [NUM_SPRITES-1:0] cfg;
    sprite_load_t                  load;
    logic                          fg_pixel;
    logic                          m2m_clr;
    logic                          m2d_clr;
    logic                          immc_clr;
    logic                          imbc_clr;
    pixel_bundle_t                 bundle;
    collision_t                    coll;

    row_t                          rows [NUM_ROWS];
    integer                        seed;
    int                            cycle_cnt = 0;

    // reference model state holds the pixels at the shifter outputs and the delay line
    logic [NUM_SPRITES-1:0][23:0]  cur_data;
    spr_pixel_t [NUM_SPRITES-1:0]  m_pix;
    logic [NUM_SPRITES-1:0]        m_mmc;
    logic [NUM_SPRITES-1:0]        m_pri;
    pixel_bundle_t                 m_pipe [DELAY_PIXELS];
    collision_t                    m_coll;
    logic                          m_mtrig;
    logic                          m_dtrig;

    sprite_top UUT (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick),
        .xpos_i     (xpos),
        .cfg_i      (cfg),
        .load_i     (load),
        .fg_pixel_i (fg_pixel),
        .m2m_clr_i  (m2m_clr),
        .m2d_clr_i  (m2d_clr),
        .immc_clr_i (immc_clr),
        .imbc_clr_i (imbc_clr),
        .bundle_o   (bundle),
        .coll_o     (coll)
    );

    always #4 clk_dot4x = ~clk_dot4x;

    // hard limit on the run that is sized from the table length
    always @(posedge clk_dot4x) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_bundle(input pixel_bundle_t got, input pixel_bundle_t exp,
                                input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: bundle %s, got %h expected %h",
                     $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "bundle check failed");
        end
    endtask

    task automatic check_coll(input collision_t got, input collision_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: collision %s, got %h expected %h",
                     $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "collision check failed");
        end
    endtask

    // pixel of one sprite at beam position t as the serializing rules define it
    function automatic spr_pixel_t pixel_at(sprite_cfg_t c, logic [23:0] d, int t);
        int s;
        int b;
        int p;
        if (!c.en || t < int'(c.x)) begin
            return '0;
        end
        s = t - int'(c.x);
        // with xe every data bit is shown for two pixels
        b = c.xe ? s / 2 : s;
        if (c.mmc) begin
            // a pair is held for two bit times
            p = b / 2;
            return (p < 12) ? d[23 - 2 * p -: 2] : 2'b00;
        end
        return (b < 24) ? {d[23 - b], 1'b0} : 2'b00;
    endfunction

    function automatic pixel_bundle_t make_bundle(spr_pixel_t [NUM_SPRITES-1:0] px,
                                                  logic [NUM_SPRITES-1:0] mmc,
                                                  logic [NUM_SPRITES-1:0] pri);
        pixel_bundle_t b;
        b.pixels = px;
        b.mmc = mmc;
        b.pri = pri;
        b.active = '0;
        // first opaque sprite counting up from zero wins
        for (int n = 0; n < NUM_SPRITES; n++) begin
            if (!b.active.valid && px[n] != 2'b00) begin
                b.active.valid = 1'b1;
                b.active.idx = SPR_IDX_W'(n);
            end
        end
        return b;
    endfunction

    task automatic coll_step(input pixel_bundle_t b, input logic fg);
        logic [NUM_SPRITES-1:0] hi;
        logic [NUM_SPRITES-1:0] vis;
        int                     cnt;
        cnt = 0;
        for (int n = 0; n < NUM_SPRITES; n++) begin
            hi[n] = b.pixels[n][1];
            vis[n] = b.mmc[n] ? (b.pixels[n] != 2'b00) : b.pixels[n][1];
            if (hi[n]) begin
                cnt++;
            end
        end
        if (cnt >= 2) begin
            m_coll.m2m |= hi;
            if (!m_mtrig) begin
                m_mtrig = 1'b1;
                m_coll.immc = 1'b1;
            end
        end
        if (fg && vis != '0) begin
            m_coll.m2d |= vis;
            if (!m_dtrig) begin
                m_dtrig = 1'b1;
                m_coll.imbc = 1'b1;
            end
        end
    endtask

    // one dot tick of the model where collisions see the bundle from before the tick
    task automatic model_step(input int t, input logic fg);
        coll_step(m_pipe[DELAY_PIXELS-1], fg);
        for (int k = DELAY_PIXELS - 1; k > 0; k--) begin
            m_pipe[k] = m_pipe[k-1];
        end
        m_pipe[0] = make_bundle(m_pix, m_mmc, m_pri);
        for (int n = 0; n < NUM_SPRITES; n++) begin
            m_pix[n] = pixel_at(cfg[n], cur_data[n], t);
            m_mmc[n] = cfg[n].mmc;
            m_pri[n] = cfg[n].pri;
        end
    endtask

    // one tick clock is followed by three quiet clocks and the checks sit on the quiet ones
    task automatic do_tick(input int t, input logic fg, input logic flag_clr);
        @(negedge clk_dot4x);
        dot_tick = 1'b1;
        xpos = XPOS_W'(t);
        fg_pixel = fg;
        @(negedge clk_dot4x);
        dot_tick = 1'b0;
        fg_pixel = 1'b0;
        model_step(t, fg);
        check_bundle(bundle, m_pipe[DELAY_PIXELS-1], $sformatf("at xpos %0d", t));
        check_coll(coll, m_coll, $sformatf("at xpos %0d", t));
        @(negedge clk_dot4x);
        if (flag_clr) begin
            immc_clr = 1'b1;
            imbc_clr = 1'b1;
            m_coll.immc = 1'b0;
            m_coll.imbc = 1'b0;
        end
        @(negedge clk_dot4x);
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
    endtask

    task automatic clear_all();
        @(negedge clk_dot4x);
        m2m_clr = 1'b1;
        m2d_clr = 1'b1;
        immc_clr = 1'b1;
        imbc_clr = 1'b1;
        @(negedge clk_dot4x);
        m2m_clr = 1'b0;
        m2d_clr = 1'b0;
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
        m_coll = '0;
        m_mtrig = 1'b0;
        m_dtrig = 1'b0;
        check_coll(coll, m_coll, "after clears");
    endtask

    task automatic load_byte(input int idx, input logic [7:0] val);
        @(negedge clk_dot4x);
        load.valid = 1'b1;
        load.idx = SPR_IDX_W'(idx);
        load.data = val;
    endtask

    task automatic set_spr(input int r, input int n, input int x, input logic en,
                           input logic xe, input logic mmc, input logic pri,
                           input logic [23:0] d);
        rows[r].cfg[n].x = XPOS_W'(x);
        rows[r].cfg[n].en = en;
        rows[r].cfg[n].xe = xe;
        rows[r].cfg[n].mmc = mmc;
        rows[r].cfg[n].pri = pri;
        rows[r].data[n] = d;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r] = '0;
        end
        // lone single-colour sprite at x 20
        set_spr(0, 0, 20, 1'b1, 1'b0, 1'b0, 1'b0, 24'hA5C3F0);
        // expanded single colour plus plain and expanded multicolour that never overlap
        set_spr(1, 2, 10, 1'b1, 1'b0, 1'b1, 1'b1, 24'h1B6E4D);
        set_spr(1, 1, 40, 1'b1, 1'b1, 1'b0, 1'b0, 24'h9F3C81);
        set_spr(1, 3, 90, 1'b1, 1'b1, 1'b1, 1'b1, 24'hC3A55A);
        // sprites 4 and 6 overlap on pixels 58 to 61
        set_spr(2, 4, 50, 1'b1, 1'b0, 1'b0, 1'b0, 24'hFFFF00);
        set_spr(2, 6, 58, 1'b1, 1'b0, 1'b0, 1'b1, 24'hF0F0F0);
        rows[2].m2m = 8'h50;
        // foreground covers pixels 24 to 39 where sprite 5 shows only code 1 and sprite 7 lies past it
        set_spr(3, 0, 20, 1'b1, 1'b0, 1'b0, 1'b0, 24'hFF00FF);
        set_spr(3, 5, 20, 1'b1, 1'b0, 1'b1, 1'b0, 24'h555555);
        set_spr(3, 7, 100, 1'b1, 1'b0, 1'b0, 1'b0, 24'hFFFFFF);
        rows[3].fg_lo = 9'd24;
        rows[3].fg_hi = 9'd40;
        rows[3].m2d = 8'h21;
        // random data for one visible sprite, one disabled sprite and one beyond the sweep
        rows[4].rnd = 1'b1;
        set_spr(4, 1, 40, 1'b1, 1'b0, 1'b0, 1'b0, 24'h0);
        set_spr(4, 2, 30, 1'b0, 1'b0, 1'b0, 1'b0, 24'h0);
        set_spr(4, 3, 300, 1'b1, 1'b0, 1'b0, 1'b0, 24'h0);
    endtask

    task automatic run_row(input int r);
        row_t       row;
        logic       fg;
        collision_t exp_c;
        row = rows[r];
        if (row.rnd) begin
            for (int n = 0; n < NUM_SPRITES; n++) begin
                row.data[n] = 24'($random(seed));
            end
        end
        cur_data = row.data;
        @(negedge clk_dot4x);
        cfg = row.cfg;
        clear_all();
        // top byte first, so the first byte ends up at bits 23 to 16
        for (int n = 0; n < NUM_SPRITES; n++) begin
            for (int b = 0; b < 3; b++) begin
                load_byte(n, row.data[n][23 - 8 * b -: 8]);
            end
        end
        @(negedge clk_dot4x);
        load = '0;
        // flush the delay line so it carries this row's mmc and pri bits
        repeat (DELAY_PIXELS) do_tick(IDLE_X, 1'b0, 1'b0);
        for (int t = 0; t < SWEEP_LEN; t++) begin
            fg = (t >= int'(row.fg_lo) + FG_LAT) && (t < int'(row.fg_hi) + FG_LAT);
            do_tick(t, fg, t == FLAG_CLR_X);
        end
        // sticky bytes must also agree with the hand-worked table values
        exp_c = m_coll;
        exp_c.m2m = row.m2m;
        exp_c.m2d = row.m2d;
        check_coll(coll, exp_c, $sformatf("at end of row %0d", r));
    endtask

    initial begin
        clk_dot4x = 1'b0;
        rst = 1'b1;
        dot_tick = 1'b0;
        xpos = '0;
        cfg = '0;
        load = '0;
        fg_pixel = 1'b0;
        m2m_clr = 1'b0;
        m2d_clr = 1'b0;
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
        seed = 56683;
        cur_data = '0;
        m_pix = '0;
        m_mmc = '0;
        m_pri = '0;
        m_coll = '0;
        m_mtrig = 1'b0;
        m_dtrig = 1'b0;
        for (int k = 0; k < DELAY_PIXELS; k++) begin
            m_pipe[k] = '0;
        end
        build_table();
        repeat (4) @(negedge clk_dot4x);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog/sprite_top.sv
module sprite_top (
    input  logic                      clk_dot4x,
    input  logic                      rst,
    input  logic                      dot_tick_i,
    input  logic [sprite_pkg::XPOS_W-1:0] xpos_i,
    input  sprite_pkg::sprite_cfg_t [sprite_pkg::NUM_SPRITES-1:0] cfg_i,
    input  sprite_pkg::sprite_load_t  load_i,
    input  logic                      fg_pixel_i,
    input  logic                      m2m_clr_i,
    input  logic                      m2d_clr_i,
    input  logic                      immc_clr_i,
    input  logic                      imbc_clr_i,
    output sprite_pkg::pixel_bundle_t bundle_o,
    output sprite_pkg::collision_t    coll_o
);

    import sprite_pkg::*;

    logic [NUM_SPRITES-1:0]       load_valid;
    spr_pixel_t [NUM_SPRITES-1:0] pixels;

    // one shifter per sprite, each sees only loads addressed to it
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_spr
        assign load_valid[i] = load_i.valid && (load_i.idx == SPR_IDX_W'(i));

        sprite_shifter u_shifter (
            .clk_dot4x    (clk_dot4x),
            .rst          (rst),
            .dot_tick_i   (dot_tick_i),
            .xpos_i       (xpos_i),
            .cfg_i        (cfg_i[i]),
            .load_valid_i (load_valid[i]),
            .load_byte_i  (load_i.data),
            .pixel_o      (pixels[i])
        );
    end

    // delay pixels into alignment with the graphics pixels
    sprite_pixel_pipe u_pipe (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .pixels_i   (pixels),
        .cfg_i      (cfg_i),
        .bundle_o   (bundle_o)
    );

    // collisions are judged on the delayed pixels, the ones actually drawn
    sprite_collision u_coll (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .dot_tick_i (dot_tick_i),
        .bundle_i   (bundle_o),
        .fg_pixel_i (fg_pixel_i),
        .m2m_clr_i  (m2m_clr_i),
        .m2d_clr_i  (m2d_clr_i),
        .immc_clr_i (immc_clr_i),
        .imbc_clr_i (imbc_clr_i),
        .coll_o     (coll_o)
    );

endmodule

// File: verilog/sprite_collision.sv
module sprite_collision (
    input  logic                      clk_dot4x,
    input  logic                      rst,
    input  logic                      dot_tick_i,
    input  sprite_pkg::pixel_bundle_t bundle_i,
    input  logic                      fg_pixel_i,
    input  logic                      m2m_clr_i,
    input  logic                      m2d_clr_i,
    input  logic                      immc_clr_i,
    input  logic                      imbc_clr_i,
    output sprite_pkg::collision_t    coll_o
);

    import sprite_pkg::*;

    collision_t             coll_q;
    collision_t             coll_d;

    // set by the first hit after a register clear, so the flag fires once
    logic                   m2m_trig_q;
    logic                   m2m_trig_d;
    logic                   m2d_trig_q;
    logic                   m2d_trig_d;

    logic [NUM_SPRITES-1:0] hi_bits;
    logic [NUM_SPRITES-1:0] visible;
    logic                   multi_hit;

    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            // sprite to sprite only looks at the high bit of each code
            hi_bits[n] = bundle_i.pixels[n][1];
            // in single colour mode code 1 is not a real pixel
            visible[n] = bundle_i.mmc[n] ? (bundle_i.pixels[n] != '0)
                                         : bundle_i.pixels[n][1];
        end
        // more than one bit set means at least two sprites overlap
        multi_hit = (hi_bits & (hi_bits - 1'b1)) != '0;
    end

    always_comb begin
        coll_d = coll_q;
        m2m_trig_d = m2m_trig_q;
        m2d_trig_d = m2d_trig_q;

        // clears go first so a hit on the same clock survives
        if (m2m_clr_i) begin
            coll_d.m2m = '0;
            m2m_trig_d = 1'b0;
        end
        if (m2d_clr_i) begin
            coll_d.m2d = '0;
            m2d_trig_d = 1'b0;
        end
        if (immc_clr_i) begin
            coll_d.immc = 1'b0;
        end
        if (imbc_clr_i) begin
            coll_d.imbc = 1'b0;
        end

        if (dot_tick_i && multi_hit) begin
            coll_d.m2m = coll_d.m2m | hi_bits;
            if (!m2m_trig_d) begin
                m2m_trig_d = 1'b1;
                coll_d.immc = 1'b1;
            end
        end
        // fg_pixel_i refers to the graphics pixel under the current bundle
        if (dot_tick_i && fg_pixel_i && (visible != '0)) begin
            coll_d.m2d = coll_d.m2d | visible;
            if (!m2d_trig_d) begin
                m2d_trig_d = 1'b1;
                coll_d.imbc = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            coll_q <= '0;
            m2m_trig_q <= 1'b0;
            m2d_trig_q <= 1'b0;
        end else begin
            coll_q <= coll_d;
            m2m_trig_q <= m2m_trig_d;
            m2d_trig_q <= m2d_trig_d;
        end
    end

    assign coll_o = coll_q;

endmodule

// File: verilog/sprite_pixel_pipe.sv
module sprite_pixel_pipe (
    input  logic                      clk_dot4x,
    input  logic                      rst,
    input  logic                      dot_tick_i,
    input  sprite_pkg::spr_pixel_t [sprite_pkg::NUM_SPRITES-1:0] pixels_i,
    input  sprite_pkg::sprite_cfg_t [sprite_pkg::NUM_SPRITES-1:0] cfg_i,
    output sprite_pkg::pixel_bundle_t bundle_o
);

    import sprite_pkg::*;

    logic [NUM_SPRITES-1:0] cfg_mmc;
    logic [NUM_SPRITES-1:0] cfg_pri;

    // mmc and pri as they were on the tick that produced the shifter pixels
    logic [NUM_SPRITES-1:0] mmc_q;
    logic [NUM_SPRITES-1:0] pri_q;

    pixel_bundle_t          cur_bundle;
    pixel_bundle_t          stage_q [DELAY_PIXELS];

    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            cfg_mmc[n] = cfg_i[n].mmc;
            cfg_pri[n] = cfg_i[n].pri;
        end
    end

    always_comb begin
        cur_bundle.pixels = pixels_i;
        cur_bundle.mmc = mmc_q;
        cur_bundle.pri = pri_q;
        cur_bundle.active = '0;
        // walk downward so the lowest opaque sprite is the one left standing
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (pixels_i[n] != '0) begin
                cur_bundle.active.valid = 1'b1;
                cur_bundle.active.idx = SPR_IDX_W'(n);
            end
        end
    end

    // the shifter pixels change on a tick, so the next tick picks them up
    // along with the mmc and pri sampled beside them
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            mmc_q <= '0;
            pri_q <= '0;
            for (int k = 0; k < DELAY_PIXELS; k++) begin
                stage_q[k] <= '0;
            end
        end else if (dot_tick_i) begin
            mmc_q <= cfg_mmc;
            pri_q <= cfg_pri;
            stage_q[0] <= cur_bundle;
            for (int k = 1; k < DELAY_PIXELS; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    // last stage lines up with the graphics pixel at the overlay point
    assign bundle_o = stage_q[DELAY_PIXELS-1];

endmodule

// File: verilog/sprite_shifter.sv
module sprite_shifter (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    input  logic                         dot_tick_i,
    input  logic [sprite_pkg::XPOS_W-1:0] xpos_i,
    input  sprite_pkg::sprite_cfg_t      cfg_i,
    input  logic                         load_valid_i,
    input  logic [sprite_pkg::BYTE_W-1:0] load_byte_i,
    output sprite_pkg::spr_pixel_t       pixel_o
);

    import sprite_pkg::*;

    // data register, bytes enter at the bottom and pixels leave near the top
    logic [SHIFT_W-1:0] shift_q;
    spr_pixel_t         pixel_q;
    logic               active_q;

    // expansion phase, when clear the current bit is repeated once more
    logic               xe_ff_q;

    // multicolour phase, when set a new bit pair is taken
    logic               mc_ff_q;

    logic               x_match;
    logic               tick_active;
    logic               xe_ph;
    logic               mc_ph;
    logic               busy;

    always_comb begin
        // the beam reaching x restarts the sprite and re-arms both phases
        x_match = cfg_i.en && (xpos_i == cfg_i.x);
        tick_active = active_q || x_match;
        xe_ph = x_match ? 1'b1 : xe_ff_q;
        mc_ph = x_match ? 1'b1 : mc_ff_q;
        // keep running while data or the last pixel is still non-zero
        busy = (shift_q != '0) || (pixel_q != '0);
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_q  <= '0;
            pixel_q  <= '0;
            active_q <= 1'b0;
            xe_ff_q  <= 1'b1;
            mc_ff_q  <= 1'b1;
        end else if (load_valid_i) begin
            // the previous low three bytes move up and the new byte lands low
            shift_q <= {shift_q[SHIFT_W-BYTE_W-1:0], load_byte_i};
        end else if (dot_tick_i && tick_active) begin
            xe_ff_q <= xe_ph;
            mc_ff_q <= mc_ph;
            if (busy) begin
                active_q <= 1'b1;
                // nothing moves on the repeat half of an expanded pixel
                if (xe_ph) begin
                    if (!cfg_i.mmc) begin
                        // single colour shows one bit as code 2 or 0
                        pixel_q <= {shift_q[FETCH_TOP], 1'b0};
                    end else begin
                        // a pair is taken every other step and then held
                        if (mc_ph) begin
                            pixel_q <= shift_q[FETCH_TOP -: PIX_W];
                        end
                        mc_ff_q <= !mc_ph;
                    end
                    shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
                end
                // without xe the phase simply stays set
                xe_ff_q <= cfg_i.xe ? !xe_ph : 1'b1;
            end else begin
                // data exhausted and pixel already transparent
                active_q <= 1'b0;
            end
        end
    end

    assign pixel_o = pixel_q;

endmodule

// File: verilog/sprite_pkg.sv
package sprite_pkg;

    // number of hardware sprites and the width of an index into them
    localparam int NUM_SPRITES = 8;
    localparam int SPR_IDX_W = 3;

    // horizontal beam position width, compared against each sprite x
    localparam int XPOS_W = 9;

    // per-sprite data register, three fetched bytes plus a drift byte on top
    localparam int SHIFT_W = 32;
    localparam int BYTE_W = 8;

    // pixels are taken from this bit downward
    // the byte above it lets the tail of the data drift out while the
    // register still reads non-zero
    localparam int FETCH_TOP = 23;

    // number of dot ticks between sprite pixel generation and the point
    // where the graphics pipeline consumes it
    localparam int DELAY_PIXELS = 6;

    // bits per sprite pixel code
    localparam int PIX_W = 2;

    // one sprite pixel, zero is transparent
    // single-colour data only ever yields 0 or 2
    typedef logic [PIX_W-1:0] spr_pixel_t;

    // register view of one sprite
    typedef struct packed {
        logic [XPOS_W-1:0] x;
        logic              en;
        logic              xe;
        logic              mmc;
        logic              pri;
    } sprite_cfg_t;

    // one byte written into one sprite's data register
    typedef struct packed {
        logic                 valid;
        logic [SPR_IDX_W-1:0] idx;
        logic [BYTE_W-1:0]    data;
    } sprite_load_t;

    // the lowest-numbered sprite that has an opaque pixel, if any
    typedef struct packed {
        logic                 valid;
        logic [SPR_IDX_W-1:0] idx;
    } active_sprite_t;

    // everything the pixel sequencer needs for one pixel position
    // mmc and pri travel with the pixel so mid-line register splits land
    // on the correct pixel
    typedef struct packed {
        spr_pixel_t [NUM_SPRITES-1:0] pixels;
        logic [NUM_SPRITES-1:0]       mmc;
        logic [NUM_SPRITES-1:0]       pri;
        active_sprite_t               active;
    } pixel_bundle_t;

    // sticky collision registers and their interrupt flags
    typedef struct packed {
        logic [NUM_SPRITES-1:0] m2m;
        logic [NUM_SPRITES-1:0] m2d;
        logic                   immc;
        logic                   imbc;
    } collision_t;

endpackage
